// File: source/branchUnit_config.svh
`ifndef BRANCH_UNIT_CONFIG_SVH
`define BRANCH_UNIT_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Architectural sizes
////////////////////////////////////////////////////////////////////////////

// Number of integer registers, x0 included
`define REG_COUNT 32

// Register and data path width
`define XLEN 32

////////////////////////////////////////////////////////////////////////////
// Link writeback
////////////////////////////////////////////////////////////////////////////

// Added to the WB pc when the link value is written back
`define LINK_STEP 4

`endif

// File: source/branchPkg.sv
`include "branchUnit_config.svh"

package branchPkg;

    ////////////////////////////////////////////////////////////////////////
    // Data and index types
    ////////////////////////////////////////////////////////////////////////

    typedef logic [`XLEN-1:0] wordT;

    // Wide enough to address every architectural register
    typedef logic [$clog2(`REG_COUNT)-1:0] regIdxT;

    ////////////////////////////////////////////////////////////////////////
    // Selects and conditions
    ////////////////////////////////////////////////////////////////////////

    // Source of the value written back in WB
    typedef enum logic [1:0] {
        wbDmem   = 2'b00,
        wbAlu    = 2'b01,
        wbPcLink = 2'b10
    } wbSelT;

    // Where a branch operand is taken from
    typedef enum logic [1:0] {
        fwdReg = 2'b00,
        fwdWb  = 2'b01,
        fwdMem = 2'b10
    } fwdSelT;

    // Decoded branch condition, brNone covers funct3 codes 2 and 3
    typedef enum logic [2:0] {
        brEq   = 3'd0,
        brNe   = 3'd1,
        brLt   = 3'd2,
        brGe   = 3'd3,
        brLtu  = 3'd4,
        brGeu  = 3'd5,
        brNone = 3'd6
    } brCondT;

    // WB result as written to the register file and forwarded to decode
    function automatic wordT wbValue(wbSelT sel, wordT dmemData, wordT aluResult, wordT pc);
        case (sel)
            wbDmem:  return dmemData;
            wbAlu:   return aluResult;
            default: return pc + wordT'(`LINK_STEP);
        endcase
    endfunction

endpackage

// File: source/pipeBus.sv
`timescale 1ns/1ps

// WB stage result and destination
interface wbBus;
    import branchPkg::*;

    logic   regWrite;
    regIdxT rd;
    wbSelT  wbSel;
    wordT   dmemData;
    wordT   aluResult;
    wordT   pc;

    modport writer (output regWrite, rd, wbSel, dmemData, aluResult, pc);
    modport reader (input regWrite, rd, wbSel, dmemData, aluResult, pc);

endinterface

// MEM stage destination and ALU result
interface memBus;
    import branchPkg::*;

    logic   regWrite;
    // Set for loads, whose data is not ready until WB
    logic   memRead;
    regIdxT rd;
    wordT   aluResult;

    modport writer (output regWrite, memRead, rd, aluResult);
    modport reader (input regWrite, memRead, rd, aluResult);

endinterface

// File: source/regFile.sv
`timescale 1ns/1ps
`include "branchUnit_config.svh"

module regFile (
    input  logic            clk,
    input  logic            rstN,
    wbBus.reader            wb,
    input  branchPkg::regIdxT rs1,
    input  branchPkg::regIdxT rs2,
    output branchPkg::wordT   rs1Data,
    output branchPkg::wordT   rs2Data
);
    import branchPkg::*;

    wordT regs [`REG_COUNT];
    wordT wbData;
    logic wbWrite;

    ////////////////////////////////////////////////////////////////////////
    // Write port from WB
    ////////////////////////////////////////////////////////////////////////

    assign wbData = wbValue(wb.wbSel, wb.dmemData, wb.aluResult, wb.pc);

    // x0 is never written
    assign wbWrite = wb.regWrite && (wb.rd != '0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWrite) begin
            regs[wb.rd] <= wbData;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////////////////////////////////////

    // Combinational reads; a same-cycle WB write reaches decode by forwarding
    always_comb begin
        rs1Data = regs[rs1];
        rs2Data = regs[rs2];
        if (rs1 == '0) begin
            rs1Data = '0;
        end
        if (rs2 == '0) begin
            rs2Data = '0;
        end
    end

endmodule

// File: source/branchForward.sv
`timescale 1ns/1ps

module branchForward (
    input  logic              idValid,
    input  branchPkg::regIdxT rs1,
    input  branchPkg::regIdxT rs2,
    input  logic              exRegWrite,
    input  branchPkg::regIdxT exRd,
    memBus.reader             mem,
    wbBus.reader              wb,
    output branchPkg::fwdSelT fwdA,
    output branchPkg::fwdSelT fwdB,
    output logic              stall
);
    import branchPkg::*;

    logic memAluValid;
    logic memLoad;
    logic exHazard;
    logic loadHazard;

    // A source matches a destination only when it is not x0
    function automatic logic hits(regIdxT src, regIdxT dst);
        return (src != '0) && (src == dst);
    endfunction

    // Newest value wins: MEM, then WB, then the register file
    function automatic fwdSelT pickSource(regIdxT src, logic memOk, logic wbOk,
                                          regIdxT memRd, regIdxT wbRd);
        if (memOk && hits(src, memRd)) begin
            return fwdMem;
        end
        if (wbOk && hits(src, wbRd)) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    ////////////////////////////////////////////////////////////////////////
    // Forward selects
    ////////////////////////////////////////////////////////////////////////

    // MEM forwards only an ALU result, load data arrives in WB
    assign memAluValid = mem.regWrite && !mem.memRead;
    assign memLoad     = mem.memRead;

    assign fwdA = pickSource(rs1, memAluValid, wb.regWrite, mem.rd, wb.rd);
    assign fwdB = pickSource(rs2, memAluValid, wb.regWrite, mem.rd, wb.rd);

    ////////////////////////////////////////////////////////////////////////
    // Hazards
    ////////////////////////////////////////////////////////////////////////

    // EX result is still in the ALU
    assign exHazard = exRegWrite && (hits(rs1, exRd) || hits(rs2, exRd));

    // Load in MEM has no data yet
    assign loadHazard = memLoad && (hits(rs1, mem.rd) || hits(rs2, mem.rd));

    assign stall = idValid && (exHazard || loadHazard);

endmodule

// File: source/branchComp.sv
`timescale 1ns/1ps

module branchComp (
    input  branchPkg::wordT   rs1Data,
    input  branchPkg::wordT   rs2Data,
    input  branchPkg::fwdSelT fwdA,
    input  branchPkg::fwdSelT fwdB,
    memBus.reader             mem,
    wbBus.reader              wb,
    input  logic              signedCmp,
    output logic              equal,
    output logic              lessThan
);
    import branchPkg::*;

    wordT wbData;
    wordT opA;
    wordT opB;

    ////////////////////////////////////////////////////////////////////////
    // Operand selection
    ////////////////////////////////////////////////////////////////////////

    // Same WB value that the register file is about to store
    assign wbData = wbValue(wb.wbSel, wb.dmemData, wb.aluResult, wb.pc);

    always_comb begin
        case (fwdA)
            fwdMem:  opA = mem.aluResult;
            fwdWb:   opA = wbData;
            default: opA = rs1Data;
        endcase
    end

    always_comb begin
        case (fwdB)
            fwdMem:  opB = mem.aluResult;
            fwdWb:   opB = wbData;
            default: opB = rs2Data;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////
    // Compare
    ////////////////////////////////////////////////////////////////////////

    assign equal = (opA == opB);

    // Signed for BLT and BGE, unsigned for BLTU and BGEU
    always_comb begin
        if (signedCmp) begin
            lessThan = $signed(opA) < $signed(opB);
        end else begin
            lessThan = opA < opB;
        end
    end

endmodule

// File: source/branchResolve.sv
`timescale 1ns/1ps

module branchResolve (
    input  logic            idValid,
    input  logic            stall,
    input  logic [2:0]      funct3,
    input  branchPkg::wordT pc,
    input  branchPkg::wordT imm,
    input  logic            equal,
    input  logic            lessThan,
    output logic            signedCmp,
    output logic            taken,
    output branchPkg::wordT target
);
    import branchPkg::*;

    brCondT cond;
    logic   condMet;

    ////////////////////////////////////////////////////////////////////////
    // Condition decode
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (funct3)
            3'b000:  cond = brEq;
            3'b001:  cond = brNe;
            3'b100:  cond = brLt;
            3'b101:  cond = brGe;
            3'b110:  cond = brLtu;
            3'b111:  cond = brGeu;
            default: cond = brNone;
        endcase
    end

    assign signedCmp = (cond == brLt) || (cond == brGe);

    ////////////////////////////////////////////////////////////////////////
    // Decision and target
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (cond)
            brEq:         condMet = equal;
            brNe:         condMet = !equal;
            brLt, brLtu:  condMet = lessThan;
            brGe, brGeu:  condMet = !lessThan;
            default:      condMet = 1'b0;
        endcase
    end

    // A stalled branch waits and decides again once its operands are ready
    assign taken = idValid && !stall && condMet;

    assign target = pc + imm;

endmodule

// File: source/branchUnitTop.sv
`timescale 1ns/1ps

module branchUnitTop (
    input  logic              clk,
    input  logic              rstN,

    // Branch in decode
    input  logic              idValid,
    input  logic [2:0]        funct3,
    input  branchPkg::regIdxT rs1,
    input  branchPkg::regIdxT rs2,
    input  branchPkg::wordT   pc,
    input  branchPkg::wordT   imm,

    // EX stage destination
    input  logic              exRegWrite,
    input  branchPkg::regIdxT exRd,

    // MEM stage
    input  logic              memRegWrite,
    input  logic              memRead,
    input  branchPkg::regIdxT memRd,
    input  branchPkg::wordT   memAluResult,

    // WB stage
    input  logic              wbRegWrite,
    input  branchPkg::regIdxT wbRd,
    input  branchPkg::wbSelT  wbSel,
    input  branchPkg::wordT   wbDmemData,
    input  branchPkg::wordT   wbAluResult,
    input  branchPkg::wordT   wbPc,

    // Resolution
    output logic              taken,
    output branchPkg::wordT   target,
    output logic              stall
);
    import branchPkg::*;

    wordT   rs1Data;
    wordT   rs2Data;
    fwdSelT fwdA;
    fwdSelT fwdB;
    logic   equal;
    logic   lessThan;
    logic   signedCmp;

    ////////////////////////////////////////////////////////////////////////
    // Stage buses
    ////////////////////////////////////////////////////////////////////////

    wbBus  wbIf ();
    memBus memIf ();

    assign wbIf.regWrite  = wbRegWrite;
    assign wbIf.rd        = wbRd;
    assign wbIf.wbSel     = wbSel;
    assign wbIf.dmemData  = wbDmemData;
    assign wbIf.aluResult = wbAluResult;
    assign wbIf.pc        = wbPc;

    assign memIf.regWrite  = memRegWrite;
    assign memIf.memRead   = memRead;
    assign memIf.rd        = memRd;
    assign memIf.aluResult = memAluResult;

    ////////////////////////////////////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////////////////////////////////////

    regFile uRegFile (
        .clk     (clk),
        .rstN    (rstN),
        .wb      (wbIf),
        .rs1     (rs1),
        .rs2     (rs2),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    branchForward uForward (
        .idValid    (idValid),
        .rs1        (rs1),
        .rs2        (rs2),
        .exRegWrite (exRegWrite),
        .exRd       (exRd),
        .mem        (memIf),
        .wb         (wbIf),
        .fwdA       (fwdA),
        .fwdB       (fwdB),
        .stall      (stall)
    );

    branchComp uComp (
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .fwdA      (fwdA),
        .fwdB      (fwdB),
        .mem       (memIf),
        .wb        (wbIf),
        .signedCmp (signedCmp),
        .equal     (equal),
        .lessThan  (lessThan)
    );

    branchResolve uResolve (
        .idValid   (idValid),
        .stall     (stall),
        .funct3    (funct3),
        .pc        (pc),
        .imm       (imm),
        .equal     (equal),
        .lessThan  (lessThan),
        .signedCmp (signedCmp),
        .taken     (taken),
        .target    (target)
    );

endmodule

// File: tests/branchUnit_chk.sv
`timescale 1ns/1ps

module branchUnit_chk (
    input logic              clk,
    input logic              rstN,
    input logic              idValid,
    input branchPkg::regIdxT rs1,
    input branchPkg::regIdxT rs2,
    input logic              exRegWrite,
    input branchPkg::regIdxT exRd,
    input logic              memRead,
    input branchPkg::regIdxT memRd,
    input logic              taken,
    input logic              stall
);
    import branchPkg::*;

    logic exMatch;
    logic loadMatch;

    // Number of failed assertions
    int failCount = 0;

    // Nonzero source waiting on EX or on a load in MEM
    assign exMatch   = exRegWrite && (((rs1 != '0) && (rs1 == exRd)) ||
                                      ((rs2 != '0) && (rs2 == exRd)));
    assign loadMatch = memRead && (((rs1 != '0) && (rs1 == memRd)) ||
                                   ((rs2 != '0) && (rs2 == memRd)));

    neverBoth: assert property (@(posedge clk) disable iff (!rstN) !(taken && stall))
        else begin
            failCount++;
            $error("taken and stall are high in the same cycle");
        end

    // Also covers the cycles during and right after reset
    idleQuiet: assert property (@(posedge clk) !idValid |-> (!taken && !stall))
        else begin
            failCount++;
            $error("taken or stall is high while idValid is low");
        end

    stallCause: assert property (@(posedge clk) disable iff (!rstN)
                                 stall |-> (exMatch || loadMatch))
        else begin
            failCount++;
            $error("stall is high without a pending destination match");
        end

endmodule

// File: tests/branchUnitTb.sv
`timescale 1ns/1ps
`include "branchUnit_config.svh"

module branchUnitTb;
    import branchPkg::*;

    typedef struct packed {
        logic stall;
        logic taken;
        wordT target;
    } expectT;

    localparam int randomLen = 300;
    localparam int memLen    = 100;
    localparam int wbLen     = 300;
    localparam int hazardLen = 150;
    localparam int miscLen   = 100;
    localparam int timeoutCycles = 2 * (randomLen + memLen + wbLen + hazardLen + miscLen);

    logic clk, rstN;
    logic idValid, exRegWrite, memRegWrite, memRead, wbRegWrite;
    logic [2:0] funct3;
    regIdxT rs1, rs2, exRd, memRd, wbRd;
    wordT pc, imm, memAluResult, wbDmemData, wbAluResult, wbPc;
    wbSelT wbSel;
    logic taken, stall;
    wordT target;

    wordT shadowRegs [`REG_COUNT];
    logic [31:0] lfsrState;
    wordT baseWord;
    string testName;
    int cycleCount;
    expectT expected;

    branchUnitTop dut0 (.*);

    bind branchUnitTop branchUnit_chk chk0 (
        .clk        (clk),
        .rstN       (rstN),
        .idValid    (idValid),
        .rs1        (rs1),
        .rs2        (rs2),
        .exRegWrite (exRegWrite),
        .exRd       (exRd),
        .memRead    (memRead),
        .memRd      (memRd),
        .taken      (taken),
        .stall      (stall)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Random source
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsrStep(logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] randBits(int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrStep(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    // Biased toward equal words and words apart only in the sign bit
    function automatic wordT pickWord();
        logic [1:0] kind;
        kind = 2'(randBits(2));
        case (kind)
            2'd0:    return baseWord;
            2'd1:    return baseWord ^ 32'h8000_0000;
            2'd2:    return randBits(8);
            default: return randBits(32);
        endcase
    endfunction

    function automatic wbSelT pickWbSel();
        logic [1:0] code;
        code = 2'(randBits(2));
        if (code == 2'b11) begin
            code = 2'b01;
        end
        return wbSelT'(code);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic wordT refWbResult();
        case (wbSel)
            wbDmem:  return wbDmemData;
            wbAlu:   return wbAluResult;
            default: return wbPc + 32'd4;
        endcase
    endfunction

    function automatic wordT refOperand(regIdxT src);
        if (src == '0) begin
            return '0;
        end
        if (memRegWrite && !memRead && (memRd == src)) begin
            return memAluResult;
        end
        if (wbRegWrite && (wbRd == src)) begin
            return refWbResult();
        end
        return shadowRegs[src];
    endfunction

    function automatic expectT refModel();
        expectT res;
        wordT a;
        wordT b;
        logic condMet;
        logic exHit;
        logic loadHit;
        a = refOperand(rs1);
        b = refOperand(rs2);
        exHit = exRegWrite && (((rs1 != '0) && (rs1 == exRd)) || ((rs2 != '0) && (rs2 == exRd)));
        loadHit = memRead && (((rs1 != '0) && (rs1 == memRd)) || ((rs2 != '0) && (rs2 == memRd)));
        case (funct3)
            3'b000:  condMet = (a == b);
            3'b001:  condMet = (a != b);
            3'b100:  condMet = ($signed(a) < $signed(b));
            3'b101:  condMet = ($signed(a) >= $signed(b));
            3'b110:  condMet = (a < b);
            3'b111:  condMet = (a >= b);
            default: condMet = 1'b0;
        endcase
        res.stall = idValid && (exHit || loadHit);
        res.taken = idValid && !res.stall && condMet;
        res.target = pc + imm;
        return res;
    endfunction

    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                shadowRegs[i] <= '0;
            end
        end else if (wbRegWrite && (wbRd != '0)) begin
            shadowRegs[wbRd] <= refWbResult();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks and timeout
    ////////////////////////////////////////////////////////////////////////////

    task automatic checkBit(string what, logic expBit, logic actBit);
        if (actBit !== expBit) begin
            $display("Mismatch in %s: %s expected %b, actual %b", testName, what, expBit, actBit);
            $display("Test failed");
            $fatal(1, "Stopping at first error");
        end
    endtask

    task automatic checkWord(string what, wordT expWord, wordT actWord);
        if (actWord !== expWord) begin
            $display("Mismatch in %s: %s expected %h, actual %h", testName, what, expWord,
                     actWord);
            $display("Test failed");
            $fatal(1, "Stopping at first error");
        end
    endtask

    // Bound assertions count their own failures
    task automatic checkAssertions();
        if (dut0.chk0.failCount != 0) begin
            $display("A bound assertion failed during %s", testName);
            $display("Test failed");
            $fatal(1, "Stopping at first error");
        end
    endtask

    // Outputs settle long before the falling edge
    always @(negedge clk) begin
        if (rstN) begin
            expected = refModel();
            checkBit("stall", expected.stall, stall);
            checkBit("taken", expected.taken, taken);
            checkWord("target", expected.target, target);
        end
        checkAssertions();
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout: run did not finish within %0d cycles", timeoutCycles);
            $display("Test failed");
            $fatal(1, "Simulation timed out");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic idleInputs();
        idValid = 1'b0;
        funct3 = '0;
        rs1 = '0;
        rs2 = '0;
        pc = '0;
        imm = '0;
        exRegWrite = 1'b0;
        exRd = '0;
        memRegWrite = 1'b0;
        memRead = 1'b0;
        memRd = '0;
        memAluResult = '0;
        wbRegWrite = 1'b0;
        wbRd = '0;
        wbSel = wbDmem;
        wbDmemData = '0;
        wbAluResult = '0;
        wbPc = '0;
    endtask

    // Valid branch on low registers with nothing pending in the pipeline
    task automatic newBranch();
        idleInputs();
        if (randBits(3) == '0) begin
            baseWord = randBits(32);
        end
        idValid = 1'b1;
        funct3 = 3'(randBits(3));
        rs1 = regIdxT'(randBits(3));
        rs2 = regIdxT'(randBits(3));
        pc = randBits(32);
        imm = randBits(32);
        memAluResult = pickWord();
        wbSel = pickWbSel();
        wbDmemData = pickWord();
        wbAluResult = pickWord();
        wbPc = pickWord();
    endtask

    task automatic runStimulus();
        regIdxT written;
        testName = "randomBranches";
        for (int i = 0; i < randomLen; i++) begin
            nextCycle();
            newBranch();
            wbRegWrite = 1'(randBits(1));
            wbRd = regIdxT'(randBits(3));
        end
        // MEM result must win over WB on the same register
        testName = "memForward";
        for (int i = 0; i < memLen; i++) begin
            nextCycle();
            newBranch();
            memRegWrite = 1'b1;
            memRd = (randBits(1) != '0) ? rs1 : rs2;
            wbRegWrite = 1'b1;
            wbRd = (randBits(1) != '0) ? memRd : regIdxT'(randBits(3));
        end
        // Forward in one cycle and read back from the register file in the next
        testName = "wbForward";
        for (int i = 0; i < wbLen / 2; i++) begin
            nextCycle();
            newBranch();
            wbRegWrite = 1'b1;
            wbRd = (randBits(1) != '0) ? rs1 : rs2;
            written = wbRd;
            nextCycle();
            newBranch();
            rs1 = written;
        end
        testName = "hazards";
        for (int i = 0; i < hazardLen; i++) begin
            nextCycle();
            newBranch();
            exRegWrite = 1'(randBits(1));
            exRd = (randBits(1) != '0) ? rs1 : regIdxT'(randBits(3));
            memRead = 1'(randBits(1));
            memRegWrite = memRead | 1'(randBits(1));
            memRd = (randBits(1) != '0) ? rs2 : regIdxT'(randBits(3));
            wbRegWrite = 1'(randBits(1));
            wbRd = regIdxT'(randBits(3));
        end
        testName = "validAndDecode";
        for (int i = 0; i < miscLen; i++) begin
            nextCycle();
            newBranch();
            idValid = 1'(randBits(1));
            rs1 = regIdxT'(randBits(5));
            rs2 = regIdxT'(randBits(5));
            exRegWrite = 1'(randBits(1));
            exRd = regIdxT'(randBits(5));
            memRead = 1'(randBits(1));
            memRegWrite = memRead | 1'(randBits(1));
            memRd = regIdxT'(randBits(5));
            wbRegWrite = 1'(randBits(1));
            wbRd = regIdxT'(randBits(5));
        end
    endtask

    initial begin
        lfsrState = 32'h6d2342f4;
        baseWord = 32'h0;
        cycleCount = 0;
        testName = "reset";
        idleInputs();
        rstN = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rstN = 1'b1;
        runStimulus();
        nextCycle();
        idleInputs();
        @(negedge clk);
        nextCycle();
        checkAssertions();
        $display("Test passed");
        $finish;
    end

endmodule

// File: compile.f
+incdir+source
source/branchPkg.sv
source/pipeBus.sv
source/regFile.sv
source/branchForward.sv
source/branchComp.sv
source/branchResolve.sv
source/branchUnitTop.sv
tests/branchUnit_chk.sv
tests/branchUnitTb.sv

// File: run.sh
#!/bin/sh
# Build the branch unit testbench with Verilator, run it and scan the log

LOG=sim.log

verilator --binary --assert -f compile.f --top-module branchUnitTb -o branchUnitTb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/branchUnitTb > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
    echo "Failure reported in $LOG"
    exit 1
fi

if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

echo "Simulation finished cleanly"
exit 0
